// ==== hw/fmul_fmt_pkg.sv ====
// Single precision float format shared by the multiplier and the top level.
// Only the IEEE 754 field layout is described here, and no special values:
// NaN and infinity have no encoding of their own in this design.
// A zero exponent means a zero leading mantissa bit, so denormals lose it.

`default_nettype none

package fmul_fmt_pkg;

    // ------------------------------------------------------------
    // field widths
    // ------------------------------------------------------------

    localparam int exp_width   = 8;
    localparam int frac_width  = 23;

    // sign + exponent + fraction
    localparam int float_width = 1 + exp_width + frac_width;

    // exponent offset, 2**(exp_width-1) - 1
    localparam int exp_bias    = 127;

    // ------------------------------------------------------------
    // pipeline
    // ------------------------------------------------------------

    // compute stages behind the input register of fmul_pipe
    localparam int pipe_stages = 5;

    // ------------------------------------------------------------
    // types
    // ------------------------------------------------------------

    // one float word, sign in the top bit
    typedef logic [float_width-1:0] float_t;

endpackage

`default_nettype wire

// ==== hw/fmul_hub_pkg.sv ====
// Client side settings of the shared multiplier hub.
// tag_t is sized from n_clients, so more clients only widen the tag.
// queue_depth applies to both request and response queues.

`default_nettype none

package fmul_hub_pkg;

    // ------------------------------------------------------------
    // clients
    // ------------------------------------------------------------

    localparam int n_clients = 2;

    // client index carried through the pipeline
    typedef logic [$clog2(n_clients)-1:0] tag_t;

    // ------------------------------------------------------------
    // queues
    // ------------------------------------------------------------

    localparam int queue_depth = 4;

    // operand pair, [1] is operand a and [0] is operand b
    typedef fmul_fmt_pkg::float_t [1:0] req_t;

endpackage

`default_nettype wire

// ==== hw/fmul_queue.sv ====
// Synchronous FIFO of queue_depth entries with a valid/ready port on each side.
// A push is seen at the output one cycle later; there is no fall-through.
// Push and pop may happen in the same cycle.
// in_ready is the not-full flag. Storage is not cleared by reset.

`timescale 1ns/10ps
`default_nettype none

module fmul_queue
    import fmul_hub_pkg::*;
#(
    parameter type item_t = logic
) (
    input  wire        clk,
    input  wire        rst_n,
    input  wire item_t in_data,
    input  wire        in_valid,
    output logic       in_ready,
    output item_t      out_data,
    output logic       out_valid,
    input  wire        out_ready
);

    typedef logic [$clog2(queue_depth)-1:0] ptr_t;

    item_t                        mem [queue_depth];
    ptr_t                         wr_ptr;
    ptr_t                         rd_ptr;
    logic [$clog2(queue_depth):0] count;
    logic                         push;
    logic                         pop;

    function automatic ptr_t next_ptr(input ptr_t ptr);
        if (ptr == ptr_t'(queue_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign in_ready  = (count != queue_depth);
    assign out_valid = (count != 0);

    // head entry straight from the storage flops
    assign out_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/fmul_rr_arbiter.sv ====
// Round-robin arbiter for the shared multiplier.
// grant and grant_idx are combinational from req and the priority pointer.
// The pointer moves one past the winner only when advance is high, so a
// grant holds steady while the pipeline is stalled.
// With no request, grant is zero and grant_idx shows the pointer.

`timescale 1ns/10ps
`default_nettype none

module fmul_rr_arbiter
    import fmul_hub_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire [n_clients-1:0]  req,
    input  wire                  advance,
    output logic [n_clients-1:0] grant,
    output tag_t                 grant_idx
);

    // first client to look at
    tag_t prio;

    // ------------------------------------------------------------
    // grant search from the pointer, wrapping around
    // ------------------------------------------------------------

    always_comb begin
        int   idx;
        logic found;

        grant     = '0;
        grant_idx = prio;
        found     = 1'b0;
        for (int i = 0; i < n_clients; i++) begin
            idx = (int'(prio) + i) % n_clients;
            if (!found && req[idx]) begin
                found      = 1'b1;
                grant[idx] = 1'b1;
                grant_idx  = tag_t'(idx);
            end
        end
    end

    // ------------------------------------------------------------
    // pointer update
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prio <= '0;
        end else if (advance) begin
            if (grant_idx == tag_t'(n_clients - 1)) begin
                prio <= '0;
            end else begin
                prio <= grant_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/fmul_pipe.sv ====
// Tagged single precision multiplier, input register plus five stages.
// out_valid rises five edges after an operand pair is accepted.
// The product is truncated, never rounded. Exponent overflow or underflow
// gives signed zero. An increment to an all-ones exponent is not caught,
// and NaN and infinity inputs are treated as ordinary numbers.
// The whole pipeline stalls while out_valid is high and out_ready is low.

`timescale 1ns/10ps
`default_nettype none

module fmul_pipe
    import fmul_fmt_pkg::*;
    import fmul_hub_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire float_t in_a,
    input  wire float_t in_b,
    input  wire tag_t   in_tag,
    input  wire         in_valid,
    output logic        in_ready,
    output float_t      out_data,
    output tag_t        out_tag,
    output logic        out_valid,
    input  wire         out_ready
);

    // one valid bit per register stage, input register at bit 0
    logic [pipe_stages:0]        vld;
    logic                        advance;

    float_t                      s0_a;
    float_t                      s0_b;
    tag_t                        s0_tag;

    logic                        s1_sign_a;
    logic [exp_width-1:0]        s1_exp_a;
    logic [frac_width:0]         s1_man_a;
    logic                        s1_sign_b;
    logic [exp_width-1:0]        s1_exp_b;
    logic [frac_width:0]         s1_man_b;
    tag_t                        s1_tag;

    logic                        s2_sign;
    logic [exp_width:0]          s2_exp;
    logic [2*frac_width+1:0]     s2_prod;
    tag_t                        s2_tag;

    logic                        s3_sign;
    logic [exp_width:0]          s3_exp;
    logic [2*frac_width+1:0]     s3_prod;
    tag_t                        s3_tag;

    logic                        s4_sign;
    logic [exp_width:0]          s4_exp;
    logic [frac_width+1:0]       s4_man;
    tag_t                        s4_tag;

    logic                        s5_sign;
    logic [exp_width-1:0]        s5_exp;
    logic [frac_width-1:0]       s5_frac;
    tag_t                        s5_tag;

    assign advance   = !out_valid || out_ready;
    assign in_ready  = advance;
    assign out_valid = vld[pipe_stages];
    assign out_data  = {s5_sign, s5_exp, s5_frac};
    assign out_tag   = s5_tag;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld <= '0;
        end else if (advance) begin
            vld <= {vld[pipe_stages-1:0], in_valid};
        end
    end

    // ------------------------------------------------------------
    // datapath, all stages move together
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (advance) begin
            s0_a   <= in_a;
            s0_b   <= in_b;
            s0_tag <= in_tag;

            // split, hidden bit only for a nonzero exponent
            s1_sign_a <= s0_a[float_width-1];
            s1_exp_a  <= s0_a[float_width-2 -: exp_width];
            s1_man_a  <= {|s0_a[float_width-2 -: exp_width], s0_a[frac_width-1:0]};
            s1_sign_b <= s0_b[float_width-1];
            s1_exp_b  <= s0_b[float_width-2 -: exp_width];
            s1_man_b  <= {|s0_b[float_width-2 -: exp_width], s0_b[frac_width-1:0]};
            s1_tag    <= s0_tag;

            // top exponent bit flags overflow and underflow
            s2_sign <= s1_sign_a ^ s1_sign_b;
            s2_exp  <= {1'b0, s1_exp_a} + {1'b0, s1_exp_b} - (exp_width + 1)'(exp_bias);
            s2_prod <= s1_man_a * s1_man_b;
            s2_tag  <= s1_tag;

            s3_sign <= s2_sign;
            s3_exp  <= s2_exp;
            s3_prod <= s2_prod;
            s3_tag  <= s2_tag;

            // drop the low fraction bits, truncation
            s4_sign <= s3_sign;
            s4_exp  <= s3_exp;
            s4_man  <= s3_prod[2*frac_width+1 -: frac_width+2];
            s4_tag  <= s3_tag;

            // normalize
            s5_sign <= s4_sign;
            s5_tag  <= s4_tag;
            if (s4_exp[exp_width]) begin
                s5_exp  <= '0;
                s5_frac <= '0;
            end else if (s4_man[frac_width+1]) begin
                s5_exp  <= s4_exp[exp_width-1:0] + 1'b1;
                s5_frac <= s4_man[frac_width:1];
            end else if (s4_man[frac_width]) begin
                s5_exp  <= s4_exp[exp_width-1:0];
                s5_frac <= s4_man[frac_width-1:0];
            end else begin
                s5_exp  <= '0;
                s5_frac <= s4_man[frac_width-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/fmul_hub.sv ====
// Shared float multiplier for n_clients clients.
// Each client has a request queue and a response queue of queue_depth.
// Request transfer to rsp_valid is 7 cycles with no back-pressure.
// A full response queue stalls the shared pipeline and so blocks every
// client, not only the one that is slow to take its results.

`timescale 1ns/10ps
`default_nettype none

module fmul_hub
    import fmul_fmt_pkg::*;
    import fmul_hub_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire float_t [n_clients-1:0] req_a,
    input  wire float_t [n_clients-1:0] req_b,
    input  wire [n_clients-1:0]         req_valid,
    output wire [n_clients-1:0]         req_ready,
    output wire float_t [n_clients-1:0] rsp_data,
    output wire [n_clients-1:0]         rsp_valid,
    input  wire [n_clients-1:0]         rsp_ready
);

    req_t                 q_data [n_clients];
    wire [n_clients-1:0]  q_valid;
    wire [n_clients-1:0]  q_pop;
    wire [n_clients-1:0]  grant;
    tag_t                 grant_idx;
    req_t                 sel;
    logic                 pipe_in_valid;
    logic                 pipe_in_ready;
    float_t               pipe_out_data;
    tag_t                 pipe_out_tag;
    logic                 pipe_out_valid;
    logic                 pipe_out_ready;
    wire [n_clients-1:0]  rsp_push;
    wire [n_clients-1:0]  rsp_in_ready;

    // ------------------------------------------------------------
    // per client queues
    // ------------------------------------------------------------

    for (genvar c = 0; c < n_clients; c++) begin : g_client
        assign q_pop[c]    = grant[c] & pipe_in_ready;
        assign rsp_push[c] = pipe_out_valid & (pipe_out_tag == tag_t'(c));

        fmul_queue #(.item_t(req_t)) u_req_q (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_data   ({req_a[c], req_b[c]}),
            .in_valid  (req_valid[c]),
            .in_ready  (req_ready[c]),
            .out_data  (q_data[c]),
            .out_valid (q_valid[c]),
            .out_ready (q_pop[c])
        );

        fmul_queue #(.item_t(float_t)) u_rsp_q (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_data   (pipe_out_data),
            .in_valid  (rsp_push[c]),
            .in_ready  (rsp_in_ready[c]),
            .out_data  (rsp_data[c]),
            .out_valid (rsp_valid[c]),
            .out_ready (rsp_ready[c])
        );
    end

    fmul_rr_arbiter u_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (q_valid),
        .advance   (pipe_in_valid && pipe_in_ready),
        .grant     (grant),
        .grant_idx (grant_idx)
    );

    // one-hot grant picks the operand pair
    always_comb begin
        sel = '0;
        for (int c = 0; c < n_clients; c++) begin
            if (grant[c]) begin
                sel = sel | q_data[c];
            end
        end
    end

    assign pipe_in_valid  = |q_valid;
    assign pipe_out_ready = rsp_in_ready[pipe_out_tag];

    fmul_pipe u_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_a      (sel[1]),
        .in_b      (sel[0]),
        .in_tag    (grant_idx),
        .in_valid  (pipe_in_valid),
        .in_ready  (pipe_in_ready),
        .out_data  (pipe_out_data),
        .out_tag   (pipe_out_tag),
        .out_valid (pipe_out_valid),
        .out_ready (pipe_out_ready)
    );

endmodule

`default_nettype wire

// ==== dv/fmul_hub_assertions.sv ====
// Handshake and grant checks, bound into the arbiter and the pipeline.
// Each bind ties the ports that its target lacks to idle values.

`timescale 1ns/10ps
`default_nettype none

module fmul_hub_assertions
    import fmul_fmt_pkg::*;
    import fmul_hub_pkg::*;
(
    input wire                 clk,
    input wire                 rst_n,
    input wire [n_clients-1:0] grant,
    input wire                 in_valid,
    input wire                 in_ready,
    input wire                 out_valid,
    input wire                 out_ready,
    input wire float_t         out_data
);

    grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant))
        else $error("grant has more than one bit set");

    // stalled output holds its word
    out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("out_data changed while stalled");

    // a pair taken in reaches the output after five advancing edges
    out_after_five: assert property (@(posedge clk) disable iff (!rst_n)
        $past(in_valid && in_ready, 5) && $past(in_ready, 4) && $past(in_ready, 3)
            && $past(in_ready, 2) && $past(in_ready, 1) && in_ready
        |=> out_valid)
        else $error("accepted pair did not reach the output");

endmodule

bind fmul_rr_arbiter fmul_hub_assertions u_arb_chk (
    .clk(clk), .rst_n(rst_n), .grant(grant), .in_valid(1'b0),
    .in_ready(1'b1), .out_valid(1'b0), .out_ready(1'b1), .out_data('0)
);

bind fmul_pipe fmul_hub_assertions u_pipe_chk (
    .clk(clk), .rst_n(rst_n), .grant('0), .in_valid(in_valid),
    .in_ready(in_ready), .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data)
);

`default_nettype wire

// ==== dv/fmul_hub_tb.sv ====
// Directed testbench for the shared float multiplier hub.
// Inputs are driven 10 ns after the rising edge. Handshakes, scoreboards and
// response checks are sampled on the falling edge, where everything is stable.
// Expected products come from ref_mul, written from the multiply rules:
// truncation, zero leading bit for a zero exponent, signed zero on exponent
// overflow or underflow, no detection of an increment to all ones.

`timescale 1ns/10ps
`default_nettype none

module fmul_hub_tb
    import fmul_fmt_pkg::*;
    import fmul_hub_pkg::*;
;

    // longest run is a few hundred cycles
    localparam int max_cycles = 4000;

    // time for the queues and the pipeline to empty
    localparam int drain_limit = 100;

    logic                         clk;
    logic                         rst_n;
    float_t [n_clients-1:0]       req_a;
    float_t [n_clients-1:0]       req_b;
    logic [n_clients-1:0]         req_valid;
    wire [n_clients-1:0]          req_ready;
    wire float_t [n_clients-1:0]  rsp_data;
    wire [n_clients-1:0]          rsp_valid;
    logic [n_clients-1:0]         rsp_ready;

    float_t  sb [n_clients][$];
    int      delivered [n_clients] = '{default: 0};
    int      cyc = 0;
    int      seed = 63;
    int      stall_seen = 0;

    fmul_hub dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_a     (req_a),
        .req_b     (req_b),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp_data  (rsp_data),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------------------
    // failure reporting and reference model
    // ------------------------------------------------------------

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] time %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    function automatic float_t ref_mul(input float_t a, input float_t b);
        logic        sign;
        int          e;
        logic [47:0] prod;
        logic [24:0] top;

        sign = a[31] ^ b[31];
        e    = int'(a[30:23]) + int'(b[30:23]) - exp_bias;
        prod = {|a[30:23], a[22:0]} * {|b[30:23], b[22:0]};
        top  = prod[47:23];
        // outside 0..255 the 9-bit exponent sum has its top bit set
        if (e < 0 || e > 255) begin
            return {sign, 31'b0};
        end
        if (top[24]) begin
            return {sign, 8'(e + 1), top[23:1]};
        end
        if (top[23]) begin
            return {sign, 8'(e), top[22:0]};
        end
        return {sign, 8'b0, top[22:0]};
    endfunction

    // normal range operands, products stay normal too
    function automatic float_t rand_float();
        logic [31:0] r;

        r = $random(seed);
        return {r[31], 8'd100 + 8'(r[30:23] % 8'd56), r[22:0]};
    endfunction

    // ------------------------------------------------------------
    // monitor, timeout
    // ------------------------------------------------------------

    always @(negedge clk) begin
        if (rst_n) begin
            for (int c = 0; c < n_clients; c++) begin
                if (req_valid[c] && req_ready[c]) begin
                    sb[c].push_back(ref_mul(req_a[c], req_b[c]));
                end
                if (rsp_valid[c] && rsp_ready[c]) begin
                    if (sb[c].size() == 0) begin
                        abort_run($sformatf("unexpected response on client %0d", c));
                    end else begin
                        check_val($sformatf("rsp_data[%0d]", c), rsp_data[c],
                                  sb[c].pop_front());
                        delivered[c]++;
                    end
                end
            end
            if (req_valid[0] && !req_ready[0]) begin
                stall_seen = 1;
            end
        end
    end

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc > max_cycles) begin
            abort_run("timeout, the run did not finish in time");
        end
    end

    // ------------------------------------------------------------
    // drivers
    // ------------------------------------------------------------

    task automatic send(input int c, input float_t a, input float_t b);
        logic ok;

        req_a[c]     = a;
        req_b[c]     = b;
        req_valid[c] = 1'b1;
        do begin
            @(negedge clk);
            ok = req_ready[c];
            @(posedge clk);
            #10;
        end while (!ok);
        req_valid[c] = 1'b0;
    endtask

    task automatic stream(input int c, input int n);
        for (int i = 0; i < n; i++) begin
            send(c, rand_float(), rand_float());
        end
    endtask

    // gives up after drain_limit cycles, a lost product stays in sb
    task automatic drain();
        int waited;

        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while ((sb[0].size() != 0 || sb[1].size() != 0) && waited < drain_limit);
        #10;
    endtask

    // expected value given by hand, then sent on client 0
    task automatic send_known(input float_t a, input float_t b, input float_t exp);
        check_val("ref_mul", ref_mul(a, b), exp);
        send(0, a, b);
    endtask

    // ------------------------------------------------------------
    // tests
    // ------------------------------------------------------------

    task automatic simple_one(input float_t a, input float_t b, input float_t exp);
        int t0;

        send_known(a, b, exp);
        t0 = cyc;
        do begin
            @(negedge clk);
        end while (!rsp_valid[0]);
        check_val("rsp_valid[0] latency", cyc - t0, 7);
        @(posedge clk);
        #10;
    endtask

    task automatic test_simple();
        simple_one(32'h3fc0_0000, 32'h4000_0000, 32'h4040_0000);
        simple_one(32'hc040_0000, 32'h3f00_0000, 32'hbfc0_0000);
        simple_one(32'h3f80_0000, 32'h3f80_0000, 32'h3f80_0000);
    endtask

    task automatic test_edge();
        send_known(32'h7f00_0000, 32'h7f00_0000, 32'h0000_0000);
        send_known(32'hff00_0000, 32'h7f00_0000, 32'h8000_0000);
        send_known(32'h0080_0000, 32'h0080_0000, 32'h0000_0000);
        send_known(32'h0000_0000, 32'h4040_0000, 32'h0000_0000);
        send_known(32'h8000_0000, 32'h3f80_0000, 32'h8000_0000);
        drain();
    endtask

    task automatic test_both_clients();
        fork
            stream(0, 20);
            stream(1, 20);
        join
        drain();
    endtask

    task automatic test_fairness();
        delivered[0] = 0;
        delivered[1] = 0;
        fork
            stream(0, 16);
            stream(1, 16);
            begin
                int gap;

                while (delivered[0] + delivered[1] < 32) begin
                    @(posedge clk);
                    if (sb[0].size() != 0 && sb[1].size() != 0) begin
                        gap = delivered[0] - delivered[1];
                        if (gap < 0) begin
                            gap = -gap;
                        end
                        if (gap > 1) begin
                            check_val("delivered count gap", gap, 1);
                        end
                    end
                end
            end
        join
        drain();
    endtask

    task automatic test_backpressure();
        stall_seen   = 0;
        delivered[1] = 0;
        fork
            stream(0, 20);
            stream(1, 8);
            begin
                int r;

                // hold client 1 off long enough to fill its response queue
                for (int i = 0; delivered[1] < 8; i++) begin
                    r = $random(seed);
                    rsp_ready[1] = (i >= 40) && r[0];
                    @(posedge clk);
                    #10;
                end
                rsp_ready[1] = 1'b1;
            end
        join
        drain();
        check_val("req_ready[0] fell under back-pressure", stall_seen, 1);
    endtask

    initial begin
        rst_n     = 1'b0;
        req_a     = '0;
        req_b     = '0;
        req_valid = '0;
        rsp_ready = '1;
        repeat (16) @(posedge clk);
        #10;
        rst_n = 1'b1;
        @(posedge clk);
        #10;

        test_simple();
        test_edge();
        test_both_clients();
        test_fairness();
        test_backpressure();

        if (sb[0].size() != 0 || sb[1].size() != 0) begin
            abort_run("expected products left over at end of run");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== flist.f ====
hw/fmul_fmt_pkg.sv
hw/fmul_hub_pkg.sv
hw/fmul_queue.sv
hw/fmul_rr_arbiter.sv
hw/fmul_pipe.sv
hw/fmul_hub.sv
dv/fmul_hub_assertions.sv
dv/fmul_hub_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= fmul_hub_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
